/* Bender.yml */
package:
  name: mem_bridge

sources:
  - logic/bridge_pkg.sv
  - logic/reset_stretch.sv
  - logic/req_slot.sv
  - logic/fetch_port.sv
  - logic/data_port.sv
  - logic/bus_arbiter.sv
  - logic/mem_bridge_top.sv
  - target: test
    files:
      - verification/mem_bridge_properties.sv
      - verification/mem_bridge_tb.sv

/* filelist.f */
logic/bridge_pkg.sv
logic/reset_stretch.sv
logic/req_slot.sv
logic/fetch_port.sv
logic/data_port.sv
logic/bus_arbiter.sv
logic/mem_bridge_top.sv
verification/mem_bridge_properties.sv
verification/mem_bridge_tb.sv

/* logic/bridge_pkg.sv */
package bridge_pkg;

    localparam int WORD_W = 32;
    localparam int STRB_W = 4;

    // Encoding follows the load/store size field of the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    typedef struct packed {
        logic [WORD_W-1:0] addr;
    } fetch_req_t;

    // Address is word aligned, the byte offset travels separately
    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic              we;
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
        access_size_t      size;
        logic              sgn;
        logic [1:0]        off;
    } data_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic              we;
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
    } bus_req_t;

endpackage

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                          Clk,
    input  logic                          i_rst,
    input  logic                          i_data_valid,
    input  bridge_pkg::data_req_t         i_data_slot,
    input  logic                          i_fetch_valid,
    input  bridge_pkg::fetch_req_t        i_fetch_slot,
    input  logic                          i_bus_rsp,
    input  logic [bridge_pkg::WORD_W-1:0] i_bus_rdata,
    output logic                          o_data_take,
    output logic                          o_fetch_take,
    output logic                          o_bus_req,
    output bridge_pkg::bus_req_t          o_bus,
    output logic                          o_data_rsp,
    output logic                          o_fetch_rsp,
    output logic [bridge_pkg::WORD_W-1:0] o_rsp_data
);

    logic                 outstanding;
    logic                 owner_data;
    bridge_pkg::bus_req_t bus_next;

    // Data wins when both slots wait
    assign o_data_take  = ~outstanding & i_data_valid;
    assign o_fetch_take = ~outstanding & ~i_data_valid & i_fetch_valid;

    always_comb begin
        if (o_data_take) begin
            bus_next.addr  = i_data_slot.addr;
            bus_next.we    = i_data_slot.we;
            bus_next.strb  = i_data_slot.strb;
            bus_next.wdata = i_data_slot.wdata;
        end else begin
            bus_next.addr  = i_fetch_slot.addr;
            bus_next.we    = 1'b0;
            bus_next.strb  = '0;
            bus_next.wdata = '0;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            outstanding <= 1'b0;
            owner_data  <= 1'b0;
            o_bus_req   <= 1'b0;
        end else begin
            o_bus_req <= o_data_take | o_fetch_take;
            if (o_data_take || o_fetch_take) begin
                outstanding <= 1'b1;
                owner_data  <= o_data_take;
            end else if (i_bus_rsp) begin
                outstanding <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (o_data_take || o_fetch_take) begin
            o_bus <= bus_next;
        end
    end

    // Response goes to whichever port owns the transaction
    assign o_data_rsp  = i_bus_rsp & outstanding & owner_data;
    assign o_fetch_rsp = i_bus_rsp & outstanding & ~owner_data;
    assign o_rsp_data  = i_bus_rdata;

endmodule

/* logic/data_port.sv */
`timescale 1ns/1ps

module data_port (
    input  logic                          Clk,
    input  logic                          i_rst,
    input  logic                          i_data_req,
    input  logic [bridge_pkg::WORD_W-1:0] i_data_addr,
    input  logic                          i_data_we,
    input  bridge_pkg::access_size_t      i_data_size,
    input  logic                          i_data_signed,
    input  logic [bridge_pkg::WORD_W-1:0] i_data_wdata,
    input  logic                          i_grant_take,
    input  logic                          i_rsp,
    input  logic [bridge_pkg::WORD_W-1:0] i_rsp_data,
    output logic                          o_slot_valid,
    output bridge_pkg::data_req_t         o_slot_req,
    output logic                          o_data_done,
    output logic [bridge_pkg::WORD_W-1:0] o_data_rdata,
    output logic                          o_data_err,
    output logic                          o_data_busy
);

    logic                          accept;
    logic                          misaligned;
    logic [bridge_pkg::STRB_W-1:0] mask;
    logic [bridge_pkg::WORD_W-1:0] lanes;
    logic [bridge_pkg::WORD_W-1:0] shifted;
    logic [bridge_pkg::WORD_W-1:0] load_val;
    bridge_pkg::data_req_t         new_req;

    assign accept = i_data_req & ~o_data_busy;

    always_comb begin
        case (i_data_size)
            bridge_pkg::SIZE_BYTE: begin
                misaligned = 1'b0;
                mask       = 4'b0001 << i_data_addr[1:0];
                lanes      = {4{i_data_wdata[7:0]}};
            end
            bridge_pkg::SIZE_HALF: begin
                misaligned = i_data_addr[0];
                mask       = 4'b0011 << i_data_addr[1:0];
                lanes      = {2{i_data_wdata[15:0]}};
            end
            bridge_pkg::SIZE_WORD: begin
                misaligned = |i_data_addr[1:0];
                mask       = 4'b1111;
                lanes      = i_data_wdata;
            end
            default: begin
                misaligned = 1'b1;
                mask       = '0;
                lanes      = i_data_wdata;
            end
        endcase
    end

    always_comb begin
        new_req.addr  = {i_data_addr[bridge_pkg::WORD_W-1:2], 2'b00};
        new_req.we    = i_data_we;
        new_req.strb  = i_data_we ? mask : '0;
        new_req.wdata = lanes;
        new_req.size  = i_data_size;
        new_req.sgn   = i_data_signed;
        new_req.off   = i_data_addr[1:0];
    end

    req_slot #(
        .payload_t(bridge_pkg::data_req_t)
    ) u_slot (
        .Clk      (Clk),
        .i_rst    (i_rst),
        .i_load   (accept & ~misaligned),
        .i_payload(new_req),
        .i_take   (i_grant_take),
        .o_valid  (o_slot_valid),
        .o_payload(o_slot_req)
    );

    // Addressed lanes down to bit 0, then extend
    assign shifted = i_rsp_data >> {o_slot_req.off, 3'b000};

    always_comb begin
        case (o_slot_req.size)
            bridge_pkg::SIZE_BYTE: begin
                load_val = {{24{o_slot_req.sgn & shifted[7]}}, shifted[7:0]};
            end
            bridge_pkg::SIZE_HALF: begin
                load_val = {{16{o_slot_req.sgn & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_val = shifted;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_data_done <= 1'b0;
            o_data_err  <= 1'b0;
            o_data_busy <= 1'b0;
        end else begin
            o_data_done <= i_rsp | (accept & misaligned);
            o_data_err  <= accept & misaligned;
            if (accept && !misaligned) begin
                o_data_busy <= 1'b1;
            end else if (i_rsp) begin
                o_data_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (i_rsp) begin
            o_data_rdata <= load_val;
        end
    end

endmodule

/* logic/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port (
    input  logic                          Clk,
    input  logic                          i_rst,
    input  logic                          i_fetch_req,
    input  logic [bridge_pkg::WORD_W-1:0] i_fetch_addr,
    input  logic                          i_grant_take,
    input  logic                          i_rsp,
    input  logic [bridge_pkg::WORD_W-1:0] i_rsp_data,
    output logic                          o_slot_valid,
    output bridge_pkg::fetch_req_t        o_slot_req,
    output logic                          o_fetch_done,
    output logic [bridge_pkg::WORD_W-1:0] o_fetch_instr,
    output logic                          o_fetch_err,
    output logic                          o_fetch_busy
);

    logic                   accept;
    logic                   misaligned;
    bridge_pkg::fetch_req_t new_req;

    assign misaligned   = |i_fetch_addr[1:0];
    assign accept       = i_fetch_req & ~o_fetch_busy;
    assign new_req.addr = i_fetch_addr;

    req_slot #(
        .payload_t(bridge_pkg::fetch_req_t)
    ) u_slot (
        .Clk      (Clk),
        .i_rst    (i_rst),
        .i_load   (accept & ~misaligned),
        .i_payload(new_req),
        .i_take   (i_grant_take),
        .o_valid  (o_slot_valid),
        .o_payload(o_slot_req)
    );

    // Misaligned fetch completes on the next edge without touching the bus
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_fetch_done <= 1'b0;
            o_fetch_err  <= 1'b0;
            o_fetch_busy <= 1'b0;
        end else begin
            o_fetch_done <= i_rsp | (accept & misaligned);
            o_fetch_err  <= accept & misaligned;
            if (accept && !misaligned) begin
                o_fetch_busy <= 1'b1;
            end else if (i_rsp) begin
                o_fetch_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (i_rsp) begin
            o_fetch_instr <= i_rsp_data;
        end
    end

endmodule

/* logic/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top #(
    parameter int RST_CNT_W = 4
) (
    input  logic                          Clk,
    input  logic                          Myreset,
    input  logic                          i_fetch_req,
    input  logic [bridge_pkg::WORD_W-1:0] i_fetch_addr,
    output logic                          o_fetch_done,
    output logic [bridge_pkg::WORD_W-1:0] o_fetch_instr,
    output logic                          o_fetch_err,
    output logic                          o_fetch_busy,
    input  logic                          i_data_req,
    input  logic [bridge_pkg::WORD_W-1:0] i_data_addr,
    input  logic                          i_data_we,
    input  bridge_pkg::access_size_t      i_data_size,
    input  logic                          i_data_signed,
    input  logic [bridge_pkg::WORD_W-1:0] i_data_wdata,
    output logic                          o_data_done,
    output logic [bridge_pkg::WORD_W-1:0] o_data_rdata,
    output logic                          o_data_err,
    output logic                          o_data_busy,
    output logic                          o_bus_req,
    output bridge_pkg::bus_req_t          o_bus,
    input  logic                          i_bus_rsp,
    input  logic [bridge_pkg::WORD_W-1:0] i_bus_rdata,
    output logic                          o_ready
);

    logic                          rst_core;
    logic                          fetch_valid;
    logic                          fetch_take;
    logic                          fetch_rsp;
    bridge_pkg::fetch_req_t        fetch_slot;
    logic                          data_valid;
    logic                          data_take;
    logic                          data_rsp;
    bridge_pkg::data_req_t         data_slot;
    logic [bridge_pkg::WORD_W-1:0] rsp_data;

    reset_stretch #(
        .RST_CNT_W(RST_CNT_W)
    ) u_reset (
        .i_clk     (Clk),
        .i_rst     (Myreset),
        .o_rst_core(rst_core),
        .o_ready   (o_ready)
    );

    fetch_port u_fetch (
        .Clk          (Clk),
        .i_rst        (rst_core),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .i_grant_take (fetch_take),
        .i_rsp        (fetch_rsp),
        .i_rsp_data   (rsp_data),
        .o_slot_valid (fetch_valid),
        .o_slot_req   (fetch_slot),
        .o_fetch_done (o_fetch_done),
        .o_fetch_instr(o_fetch_instr),
        .o_fetch_err  (o_fetch_err),
        .o_fetch_busy (o_fetch_busy)
    );

    data_port u_data (
        .Clk          (Clk),
        .i_rst        (rst_core),
        .i_data_req   (i_data_req),
        .i_data_addr  (i_data_addr),
        .i_data_we    (i_data_we),
        .i_data_size  (i_data_size),
        .i_data_signed(i_data_signed),
        .i_data_wdata (i_data_wdata),
        .i_grant_take (data_take),
        .i_rsp        (data_rsp),
        .i_rsp_data   (rsp_data),
        .o_slot_valid (data_valid),
        .o_slot_req   (data_slot),
        .o_data_done  (o_data_done),
        .o_data_rdata (o_data_rdata),
        .o_data_err   (o_data_err),
        .o_data_busy  (o_data_busy)
    );

    bus_arbiter u_arb (
        .Clk          (Clk),
        .i_rst        (rst_core),
        .i_data_valid (data_valid),
        .i_data_slot  (data_slot),
        .i_fetch_valid(fetch_valid),
        .i_fetch_slot (fetch_slot),
        .i_bus_rsp    (i_bus_rsp),
        .i_bus_rdata  (i_bus_rdata),
        .o_data_take  (data_take),
        .o_fetch_take (fetch_take),
        .o_bus_req    (o_bus_req),
        .o_bus        (o_bus),
        .o_data_rsp   (data_rsp),
        .o_fetch_rsp  (fetch_rsp),
        .o_rsp_data   (rsp_data)
    );

endmodule

/* logic/req_slot.sv */
`timescale 1ns/1ps

module req_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     Clk,
    input  logic     i_rst,
    input  logic     i_load,
    input  payload_t i_payload,
    input  logic     i_take,
    output logic     o_valid,
    output payload_t o_payload
);

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (i_load) begin
            o_valid <= 1'b1;
        end else if (i_take) begin
            o_valid <= 1'b0;
        end
    end

    // Payload stays put after the take, the port reads it on the response
    always_ff @(posedge Clk) begin
        if (i_load) begin
            o_payload <= i_payload;
        end
    end

endmodule

/* logic/reset_stretch.sv */
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RST_CNT_W = 4
) (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_rst_core,
    output logic o_ready
);

    logic [RST_CNT_W-1:0] cnt;
    logic                 cnt_full;

    assign cnt_full = &cnt;

    // Counter stops once saturated, core reset drops on the next edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt        <= '0;
            o_rst_core <= 1'b1;
            o_ready    <= 1'b0;
        end else begin
            if (!cnt_full) begin
                cnt <= cnt + 1'b1;
            end
            o_rst_core <= ~cnt_full;
            o_ready    <= cnt_full;
        end
    end

endmodule

/* verification/mem_bridge_properties.sv */
`timescale 1ns/1ps

module mem_bridge_properties (
    input logic                  Clk,
    input logic                  i_rst,
    input logic                  i_bus_req,
    input logic                  i_bus_rsp,
    input logic                  i_data_valid,
    input logic                  i_fetch_valid,
    input logic                  i_data_take,
    input bridge_pkg::data_req_t i_data_slot
);

    logic pending;

    // Lanes covered by an access of the given size starting at the offset
    function automatic logic [3:0] lanes_for(
        input bridge_pkg::access_size_t size,
        input logic [1:0]               off
    );
        int         n;
        logic [3:0] m;
        n = (size == bridge_pkg::SIZE_BYTE) ? 1 : (size == bridge_pkg::SIZE_HALF) ? 2 : 4;
        for (int k = 0; k < 4; k++) begin
            m[k] = (k >= int'(off)) && (k < int'(off) + n);
        end
        return m;
    endfunction

    // Set by a bus request, cleared by its response
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            pending <= 1'b0;
        end else if (i_bus_req) begin
            pending <= 1'b1;
        end else if (i_bus_rsp) begin
            pending <= 1'b0;
        end
    end

    a_one_outstanding: assert property (@(posedge Clk) disable iff (i_rst)
        i_bus_req |-> !pending)
        else $error("o_bus_req raised while a bus transaction was outstanding");

    // A slot only empties when it is taken
    a_single_take: assert property (@(posedge Clk) disable iff (i_rst)
        !($fell(i_data_valid) && $fell(i_fetch_valid)))
        else $error("data and fetch slots taken in the same cycle");

    a_store_lanes: assert property (@(posedge Clk) disable iff (i_rst)
        (i_data_take && i_data_slot.we && (i_data_slot.strb != '0))
            |-> (i_data_slot.strb == lanes_for(i_data_slot.size, i_data_slot.off)))
        else $error("store strobes do not match access size and offset");

endmodule

bind bus_arbiter mem_bridge_properties u_props (
    .Clk          (Clk),
    .i_rst        (i_rst),
    .i_bus_req    (o_bus_req),
    .i_bus_rsp    (i_bus_rsp),
    .i_data_valid (i_data_valid),
    .i_fetch_valid(i_fetch_valid),
    .i_data_take  (o_data_take),
    .i_data_slot  (i_data_slot)
);

/* verification/mem_bridge_tb.sv */
`timescale 1ns/1ps

module mem_bridge_tb;

    localparam int TIMEOUT = 50;

    logic                          Clk;
    logic                          Myreset;
    logic                          i_fetch_req;
    logic [bridge_pkg::WORD_W-1:0] i_fetch_addr;
    logic                          o_fetch_done;
    logic [bridge_pkg::WORD_W-1:0] o_fetch_instr;
    logic                          o_fetch_err;
    logic                          o_fetch_busy;
    logic                          i_data_req;
    logic [bridge_pkg::WORD_W-1:0] i_data_addr;
    logic                          i_data_we;
    bridge_pkg::access_size_t      i_data_size;
    logic                          i_data_signed;
    logic [bridge_pkg::WORD_W-1:0] i_data_wdata;
    logic                          o_data_done;
    logic [bridge_pkg::WORD_W-1:0] o_data_rdata;
    logic                          o_data_err;
    logic                          o_data_busy;
    logic                          o_bus_req;
    bridge_pkg::bus_req_t          o_bus;
    logic                          i_bus_rsp;
    logic [bridge_pkg::WORD_W-1:0] i_bus_rdata;
    logic                          o_ready;

    logic [31:0] mem [0:255];
    logic [31:0] ref_mem [0:255];
    logic [31:0] bus_addr_log [$];
    integer      seed = 93;
    int          bus_reqs;
    int          errors;
    int          checks;
    int          tests;
    int          test_start_errors;

    mem_bridge_top #(
        .RST_CNT_W(4)
    ) UUT (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    task automatic tick();
        @(posedge Clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            $display("Test %0d %s: %0d check(s) failed", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    function automatic bridge_pkg::access_size_t size_for(input int nbytes);
        case (nbytes)
            1:       return bridge_pkg::SIZE_BYTE;
            2:       return bridge_pkg::SIZE_HALF;
            default: return bridge_pkg::SIZE_WORD;
        endcase
    endfunction

    // Picks the addressed bytes out of a word and widens them
    function automatic logic [31:0] extend_lanes(
        input logic [31:0] word,
        input int          nbytes,
        input int          off,
        input logic        sgn
    );
        logic [31:0] v;
        logic        top;
        v = '0;
        for (int k = 0; k < nbytes; k++) begin
            v[k*8 +: 8] = word[(off+k)*8 +: 8];
        end
        top = sgn & v[nbytes*8-1];
        for (int k = nbytes * 8; k < 32; k++) begin
            v[k] = top;
        end
        return v;
    endfunction

    task automatic do_fetch(
        input  logic [31:0] addr,
        output logic [31:0] instr,
        output logic        err,
        output int          cycles
    );
        i_fetch_addr = addr;
        i_fetch_req  = 1'b1;
        tick();
        i_fetch_req = 1'b0;
        cycles      = 1;
        while (o_fetch_done !== 1'b1) begin
            if (cycles >= TIMEOUT) give_up("o_fetch_done");
            check("o_fetch_busy", o_fetch_busy, 1'b1);
            tick();
            cycles++;
        end
        check("o_fetch_busy at done", o_fetch_busy, 1'b0);
        instr = o_fetch_instr;
        err   = o_fetch_err;
    endtask

    task automatic do_data(
        input  logic [31:0]              addr,
        input  logic                     we,
        input  bridge_pkg::access_size_t size,
        input  logic                     sgn,
        input  logic [31:0]              wdata,
        output logic [31:0]              rdata,
        output logic                     err,
        output int                       cycles
    );
        i_data_addr   = addr;
        i_data_we     = we;
        i_data_size   = size;
        i_data_signed = sgn;
        i_data_wdata  = wdata;
        i_data_req    = 1'b1;
        tick();
        i_data_req = 1'b0;
        cycles     = 1;
        while (o_data_done !== 1'b1) begin
            if (cycles >= TIMEOUT) give_up("o_data_done");
            check("o_data_busy", o_data_busy, 1'b1);
            tick();
            cycles++;
        end
        check("o_data_busy at done", o_data_busy, 1'b0);
        rdata = o_data_rdata;
        err   = o_data_err;
    endtask

    // Memory model with random latency, applies strobes on stores
    initial begin : memory_model
        bridge_pkg::bus_req_t req;
        int                   lat;
        i_bus_rsp   = 1'b0;
        i_bus_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = 32'h9E37_79B9 * (i + 1);
            ref_mem[i] = mem[i];
        end
        forever begin
            @(posedge Clk);
            #1;
            if (o_bus_req === 1'b1) begin
                check("o_ready at o_bus_req", o_ready, 1'b1);
                bus_reqs++;
                req = o_bus;
                bus_addr_log.push_back(req.addr);
                lat = 1 + ($unsigned($random(seed)) % 8);
                repeat (lat) @(posedge Clk);
                #1;
                i_bus_rdata = mem[req.addr[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (req.we && req.strb[b]) begin
                        mem[req.addr[9:2]][b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                end
                i_bus_rsp = 1'b1;
                @(posedge Clk);
                #1;
                i_bus_rsp = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] got;
        logic [31:0] instr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        err;
        logic        got_f;
        logic        got_d;
        int          cycles;
        int          n;
        Myreset       = 1'b1;
        i_fetch_req   = 1'b0;
        i_fetch_addr  = '0;
        i_data_req    = 1'b0;
        i_data_addr   = '0;
        i_data_we     = 1'b0;
        i_data_size   = bridge_pkg::SIZE_WORD;
        i_data_signed = 1'b0;
        i_data_wdata  = '0;
        repeat (8) tick();
        Myreset = 1'b0;

        // A load strobed during the stretch must be ignored
        n = 0;
        while (o_ready !== 1'b1) begin
            if (n >= TIMEOUT) give_up("o_ready");
            i_data_req = (n == 3);
            tick();
            n++;
            if (o_ready !== 1'b1) begin
                check("o_bus_req/done/busy in reset",
                      {o_bus_req, o_fetch_done, o_data_done, o_fetch_busy, o_data_busy}, '0);
            end
        end
        i_data_req = 1'b0;
        check("cycles to o_ready", n, 16);
        finish_test("reset stretch");

        do_fetch(32'h0000_0024, instr, err, cycles);
        check("o_fetch_instr", instr, ref_mem[9]);
        check("o_fetch_err", err, 1'b0);
        do_fetch(32'h0000_03FC, instr, err, cycles);
        check("o_fetch_instr", instr, ref_mem[255]);
        finish_test("aligned fetch");

        for (int nb = 1; nb <= 4; nb *= 2) begin
            for (int off = 0; off < 4; off += nb) begin
                addr  = 32'h0000_0200 + 32'(nb * 16) + 32'(off);
                wdata = $random(seed);
                do_data(addr, 1'b1, size_for(nb), 1'b0, wdata, got, err, cycles);
                check("o_data_err", err, 1'b0);
                for (int k = 0; k < nb; k++) begin
                    ref_mem[addr[9:2]][(off+k)*8 +: 8] = wdata[k*8 +: 8];
                end
                do_data({addr[31:2], 2'b00}, 1'b0, bridge_pkg::SIZE_WORD, 1'b0, '0,
                        got, err, cycles);
                check("o_data_rdata", got, ref_mem[addr[9:2]]);
            end
        end
        // Both signs present in bytes and halves
        do_data(32'h0000_0230, 1'b1, bridge_pkg::SIZE_WORD, 1'b0, 32'h80F7_7F01,
                got, err, cycles);
        ref_mem[8'h8C] = 32'h80F7_7F01;
        for (int nb = 1; nb <= 2; nb++) begin
            for (int off = 0; off < 4; off += nb) begin
                for (int sgn = 0; sgn < 2; sgn++) begin
                    do_data(32'h0000_0230 + 32'(off), 1'b0, size_for(nb), sgn[0], '0,
                            got, err, cycles);
                    check("o_data_rdata", got, extend_lanes(ref_mem[8'h8C], nb, off, sgn[0]));
                end
            end
        end
        finish_test("stores and loads");

        n = bus_reqs;
        do_fetch(32'h0000_0102, instr, err, cycles);
        check("o_fetch_err", err, 1'b1);
        check("fetch error latency", cycles, 1);
        do_data(32'h0000_0105, 1'b0, bridge_pkg::SIZE_HALF, 1'b0, '0, got, err, cycles);
        check("o_data_err", err, 1'b1);
        check("half error latency", cycles, 1);
        do_data(32'h0000_0106, 1'b1, bridge_pkg::SIZE_WORD, 1'b0, '1, got, err, cycles);
        check("o_data_err", err, 1'b1);
        check("word error latency", cycles, 1);
        // Long enough for a wrongly loaded slot to reach the bus
        repeat (2) tick();
        check("bus request count", bus_reqs, n);
        finish_test("misaligned access");

        bus_addr_log.delete();
        i_fetch_addr  = 32'h0000_0040;
        i_data_addr   = 32'h0000_0232;
        i_data_we     = 1'b0;
        i_data_size   = bridge_pkg::SIZE_HALF;
        i_data_signed = 1'b1;
        i_fetch_req   = 1'b1;
        i_data_req    = 1'b1;
        tick();
        i_fetch_req = 1'b0;
        i_data_req  = 1'b0;
        got_f       = 1'b0;
        got_d       = 1'b0;
        n           = 1;
        while (!(got_f && got_d)) begin
            if (n >= 2 * TIMEOUT) give_up("both done strobes");
            tick();
            n++;
            if (o_fetch_done === 1'b1) begin
                got_f = 1'b1;
                instr = o_fetch_instr;
            end
            if (o_data_done === 1'b1) begin
                got_d = 1'b1;
                got   = o_data_rdata;
            end
        end
        check("o_fetch_instr", instr, ref_mem[16]);
        check("o_data_rdata", got, extend_lanes(ref_mem[8'h8C], 2, 2, 1'b1));
        check("bus request count", bus_addr_log.size(), 2);
        check("first o_bus.addr", bus_addr_log[0], 32'h0000_0230);
        finish_test("fetch and load contention");

        $display("Tests: %0d, checks: %0d, failed checks: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
